/* hw/rv_exec_pkg.sv */
package rv_exec_pkg;

   // ########################################
   // Widths
   // ########################################

   typedef logic [63:0] xlen_t;     // Data word
   typedef logic [31:0] inst_t;     // Instruction word
   typedef logic [4:0]  reg_idx_t;  // Register index
   typedef logic [61:0] pc_tgt_t;   // Target PC[63:2]

   // ########################################
   // ALU select layout
   // ########################################

   localparam int ALU_OPW = 21;

   typedef enum logic [4:0] {
      ALU_OP_LUI,
      ALU_OP_AUIPC,
      ALU_OP_JAL,
      ALU_OP_JALR,
      ALU_OP_ADD,
      ALU_OP_SUB,
      ALU_OP_AND,
      ALU_OP_OR,
      ALU_OP_XOR,
      ALU_OP_SLL,
      ALU_OP_SRL,
      ALU_OP_SRA,
      ALU_OP_SLTI,
      ALU_OP_SLTIU,
      ALU_OP_ADDIW,
      ALU_OP_BEQ,
      ALU_OP_BNE,
      ALU_OP_BLT,
      ALU_OP_BGE,
      ALU_OP_BLTU,
      ALU_OP_BGEU
   } alu_op_e;

   typedef logic [ALU_OPW-1:0] alu_sel_t;  // One-hot, indexed by alu_op_e

   // Major opcodes
   localparam logic [6:0] OPC_LUI       = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
   localparam logic [6:0] OPC_JAL       = 7'b1101111;
   localparam logic [6:0] OPC_JALR      = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
   localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
   localparam logic [6:0] OPC_OP        = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;

   // One decoded operation
   typedef struct packed {
      logic     valid;
      alu_sel_t fu_sel;     // Zero when not valid
      xlen_t    pc;
      xlen_t    operand1;
      xlen_t    operand2;
      xlen_t    rop2;       // Compare operand for branches
      reg_idx_t rd;
      logic     wen;
      logic     illegal;
   } dec_op_t;

endpackage

/* hw/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_valid,
   input  rv_exec_pkg::inst_t   i_inst,
   input  rv_exec_pkg::xlen_t   i_pc,
   input  rv_exec_pkg::xlen_t   i_rs1_data,
   input  rv_exec_pkg::xlen_t   i_rs2_data,
   input  logic                 i_flush,
   output rv_exec_pkg::dec_op_t o_op
);

   logic [6:0]            opcode;
   logic [2:0]            funct3;
   logic [6:0]            funct7;
   rv_exec_pkg::xlen_t    imm_i;
   rv_exec_pkg::xlen_t    imm_u;
   rv_exec_pkg::xlen_t    imm_j;
   rv_exec_pkg::xlen_t    imm_b;
   rv_exec_pkg::xlen_t    shamt_i;
   rv_exec_pkg::xlen_t    rs2_sh;
   rv_exec_pkg::alu_sel_t sel;
   rv_exec_pkg::xlen_t    op2;
   logic                  wen;
   logic                  illegal;
   logic                  take;
   rv_exec_pkg::dec_op_t  op_q;

   assign opcode = i_inst[6:0];
   assign funct3 = i_inst[14:12];
   assign funct7 = i_inst[31:25];

   // ########################################
   // Immediates
   // ########################################

   assign imm_i   = {{52{i_inst[31]}}, i_inst[31:20]};
   assign imm_u   = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
   assign imm_j   = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                     i_inst[30:21], 1'b0};
   assign imm_b   = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                     i_inst[11:8], 1'b0};
   assign shamt_i = {58'b0, i_inst[25:20]};   // RV64 shift amount
   assign rs2_sh  = {58'b0, i_rs2_data[5:0]};

   // ########################################
   // Select and operand2
   // ########################################

   always_comb begin
      sel     = '0;
      op2     = '0;
      wen     = 1'b0;
      illegal = 1'b0;
      case (opcode)
         rv_exec_pkg::OPC_LUI: begin
            sel[rv_exec_pkg::ALU_OP_LUI] = 1'b1;
            op2 = imm_u;
            wen = 1'b1;
         end
         rv_exec_pkg::OPC_AUIPC: begin
            sel[rv_exec_pkg::ALU_OP_AUIPC] = 1'b1;
            op2 = imm_u;
            wen = 1'b1;
         end
         rv_exec_pkg::OPC_JAL: begin
            sel[rv_exec_pkg::ALU_OP_JAL] = 1'b1;
            op2 = imm_j;
            wen = 1'b1;
         end
         rv_exec_pkg::OPC_JALR: begin
            sel[rv_exec_pkg::ALU_OP_JALR] = 1'b1;
            op2 = imm_i;
            wen = 1'b1;
            illegal = (funct3 != 3'b000);
         end
         rv_exec_pkg::OPC_BRANCH: begin
            op2 = imm_b;                     // No writeback
            case (funct3)
               3'b000:  sel[rv_exec_pkg::ALU_OP_BEQ]  = 1'b1;
               3'b001:  sel[rv_exec_pkg::ALU_OP_BNE]  = 1'b1;
               3'b100:  sel[rv_exec_pkg::ALU_OP_BLT]  = 1'b1;
               3'b101:  sel[rv_exec_pkg::ALU_OP_BGE]  = 1'b1;
               3'b110:  sel[rv_exec_pkg::ALU_OP_BLTU] = 1'b1;
               3'b111:  sel[rv_exec_pkg::ALU_OP_BGEU] = 1'b1;
               default: illegal = 1'b1;
            endcase
         end
         rv_exec_pkg::OPC_OP_IMM: begin
            op2 = imm_i;
            wen = 1'b1;
            case (funct3)
               3'b000: sel[rv_exec_pkg::ALU_OP_ADD]   = 1'b1;
               3'b010: sel[rv_exec_pkg::ALU_OP_SLTI]  = 1'b1;
               3'b011: sel[rv_exec_pkg::ALU_OP_SLTIU] = 1'b1;
               3'b100: sel[rv_exec_pkg::ALU_OP_XOR]   = 1'b1;
               3'b110: sel[rv_exec_pkg::ALU_OP_OR]    = 1'b1;
               3'b111: sel[rv_exec_pkg::ALU_OP_AND]   = 1'b1;
               3'b001: begin
                  op2 = shamt_i;
                  sel[rv_exec_pkg::ALU_OP_SLL] = 1'b1;
                  illegal = (funct7[6:1] != 6'b000000);
               end
               default: begin                // 101, SRLI or SRAI
                  op2 = shamt_i;
                  if (funct7[6:1] == 6'b000000)
                     sel[rv_exec_pkg::ALU_OP_SRL] = 1'b1;
                  else if (funct7[6:1] == 6'b010000)
                     sel[rv_exec_pkg::ALU_OP_SRA] = 1'b1;
                  else
                     illegal = 1'b1;
               end
            endcase
         end
         rv_exec_pkg::OPC_OP: begin
            op2 = i_rs2_data;
            wen = 1'b1;
            case ({funct7, funct3})
               10'b0000000_000: sel[rv_exec_pkg::ALU_OP_ADD]   = 1'b1;
               10'b0100000_000: sel[rv_exec_pkg::ALU_OP_SUB]   = 1'b1;
               10'b0000000_010: sel[rv_exec_pkg::ALU_OP_SLTI]  = 1'b1;  // SLT
               10'b0000000_011: sel[rv_exec_pkg::ALU_OP_SLTIU] = 1'b1;  // SLTU
               10'b0000000_100: sel[rv_exec_pkg::ALU_OP_XOR]   = 1'b1;
               10'b0000000_110: sel[rv_exec_pkg::ALU_OP_OR]    = 1'b1;
               10'b0000000_111: sel[rv_exec_pkg::ALU_OP_AND]   = 1'b1;
               10'b0000000_001: begin
                  sel[rv_exec_pkg::ALU_OP_SLL] = 1'b1;
                  op2 = rs2_sh;
               end
               10'b0000000_101: begin
                  sel[rv_exec_pkg::ALU_OP_SRL] = 1'b1;
                  op2 = rs2_sh;
               end
               10'b0100000_101: begin
                  sel[rv_exec_pkg::ALU_OP_SRA] = 1'b1;
                  op2 = rs2_sh;
               end
               default: illegal = 1'b1;
            endcase
         end
         rv_exec_pkg::OPC_OP_IMM_32: begin
            sel[rv_exec_pkg::ALU_OP_ADDIW] = 1'b1;
            op2 = imm_i;
            wen = 1'b1;
            illegal = (funct3 != 3'b000);
         end
         default: illegal = 1'b1;
      endcase
      if (illegal) begin
         sel = '0;
         wen = 1'b0;
      end
   end

   // Shadow of a taken control transfer is dropped
   assign take = i_valid & ~i_flush;

   always_ff @(posedge i_clk) begin
      op_q.pc       <= i_pc;
      op_q.operand1 <= i_rs1_data;
      op_q.operand2 <= op2;
      op_q.rop2     <= i_rs2_data;
      op_q.rd       <= i_inst[11:7];
      if (!i_rst_n) begin
         op_q.valid   <= 1'b0;
         op_q.fu_sel  <= '0;
         op_q.wen     <= 1'b0;
         op_q.illegal <= 1'b0;
      end else begin
         op_q.valid   <= take;
         op_q.fu_sel  <= take ? sel : '0;
         op_q.wen     <= take & wen;
         op_q.illegal <= take & illegal;
      end
   end

   assign o_op = op_q;

   a_sel_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $onehot0(op_q.fu_sel));

endmodule

/* hw/alu.sv */
`timescale 1ns/1ns

module alu (
   input  rv_exec_pkg::alu_sel_t i_fu_sel,
   input  rv_exec_pkg::xlen_t    i_pc,
   input  rv_exec_pkg::xlen_t    i_operand1,
   input  rv_exec_pkg::xlen_t    i_operand2,
   input  rv_exec_pkg::xlen_t    i_rop2,
   output rv_exec_pkg::xlen_t    o_result,
   output logic                  o_flush,
   output rv_exec_pkg::pc_tgt_t  o_pc_tgt
);

   rv_exec_pkg::xlen_t out_lui, out_auipc, out_jal;
   rv_exec_pkg::xlen_t out_add, out_sub, out_addiw;
   rv_exec_pkg::xlen_t out_and, out_or, out_xor;
   rv_exec_pkg::xlen_t out_sll, out_srl, out_sra;
   rv_exec_pkg::xlen_t out_slti, out_sltiu;
   rv_exec_pkg::xlen_t tgt_pc, tgt_reg;
   logic               bcc;
   logic               is_jal;
   logic               is_jalr;

   assign is_jal  = i_fu_sel[rv_exec_pkg::ALU_OP_JAL];
   assign is_jalr = i_fu_sel[rv_exec_pkg::ALU_OP_JALR];

   assign out_lui   = i_operand2;
   assign out_auipc = i_pc + i_operand2;
   assign out_jal   = {i_pc[63:2] + 62'd1, 2'b00};  // Link address

   assign out_add   = i_operand1 + i_operand2;
   assign out_sub   = i_operand1 - i_operand2;
   assign out_addiw = {{32{out_add[31]}}, out_add[31:0]};

   assign out_and = i_operand1 & i_operand2;
   assign out_or  = i_operand1 | i_operand2;
   assign out_xor = i_operand1 ^ i_operand2;
   assign out_sll = i_operand1 << i_operand2[5:0];
   assign out_srl = i_operand1 >> i_operand2[5:0];
   assign out_sra = $signed(i_operand1) >>> i_operand2[5:0];

   assign out_slti  = {63'b0, $signed(i_operand1) < $signed(i_operand2)};
   assign out_sltiu = {63'b0, i_operand1 < i_operand2};

   // Select is one-hot so the masked terms never overlap
   assign o_result =
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_LUI]}}   & out_lui)   |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_AUIPC]}} & out_auipc) |
      ({64{is_jal | is_jalr}}                    & out_jal)   |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_ADD]}}   & out_add)   |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_SUB]}}   & out_sub)   |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_AND]}}   & out_and)   |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_OR]}}    & out_or)    |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_XOR]}}   & out_xor)   |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_SLL]}}   & out_sll)   |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_SRL]}}   & out_srl)   |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_SRA]}}   & out_sra)   |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_SLTI]}}  & out_slti)  |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_SLTIU]}} & out_sltiu) |
      ({64{i_fu_sel[rv_exec_pkg::ALU_OP_ADDIW]}} & out_addiw);

   // ########################################
   // Branch condition and target
   // ########################################

   always_comb begin
      bcc = 1'b0;
      if (i_fu_sel[rv_exec_pkg::ALU_OP_BEQ])
         bcc = (i_operand1 == i_rop2);
      else if (i_fu_sel[rv_exec_pkg::ALU_OP_BNE])
         bcc = (i_operand1 != i_rop2);
      else if (i_fu_sel[rv_exec_pkg::ALU_OP_BLT])
         bcc = ($signed(i_operand1) < $signed(i_rop2));
      else if (i_fu_sel[rv_exec_pkg::ALU_OP_BGE])
         bcc = ($signed(i_operand1) >= $signed(i_rop2));
      else if (i_fu_sel[rv_exec_pkg::ALU_OP_BLTU])
         bcc = (i_operand1 < i_rop2);
      else if (i_fu_sel[rv_exec_pkg::ALU_OP_BGEU])
         bcc = (i_operand1 >= i_rop2);
   end

   assign o_flush = is_jal | is_jalr | bcc;

   assign tgt_pc  = i_pc + i_operand2;
   assign tgt_reg = i_operand1 + i_operand2;

   always_comb begin
      if (is_jal | bcc)
         o_pc_tgt = tgt_pc[63:2];
      else if (is_jalr)
         o_pc_tgt = tgt_reg[63:2];
      else
         o_pc_tgt = '0;
   end

endmodule

/* hw/exec_result.sv */
`timescale 1ns/1ns

module exec_result (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  rv_exec_pkg::dec_op_t  i_op,
   input  rv_exec_pkg::xlen_t    i_result,
   input  logic                  i_flush,
   input  rv_exec_pkg::pc_tgt_t  i_pc_tgt,
   output logic                  o_wb_valid,
   output rv_exec_pkg::reg_idx_t o_wb_rd,
   output rv_exec_pkg::xlen_t    o_wb_data,
   output logic                  o_flush,
   output rv_exec_pkg::pc_tgt_t  o_pc_tgt,
   output logic                  o_illegal
);

   logic wb_strobe;

   assign wb_strobe = i_op.valid & i_op.wen & ~i_op.illegal;

   // ########################################
   // Output registers
   // ########################################

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_wb_valid <= 1'b0;
         o_wb_data  <= '0;
         o_flush    <= 1'b0;
         o_pc_tgt   <= '0;
         o_illegal  <= 1'b0;
      end else begin
         o_wb_valid <= wb_strobe;
         if (wb_strobe)
            o_wb_data <= i_result;
         o_flush    <= i_flush;
         o_pc_tgt   <= i_flush ? i_pc_tgt : '0;  // Zero unless redirecting
         o_illegal  <= i_op.valid & i_op.illegal;
      end
   end

   always_ff @(posedge i_clk) begin
      if (wb_strobe)
         o_wb_rd <= i_op.rd;
   end

   // Illegal ops carry a zero select, so the ALU cannot redirect on them
   a_no_flush_on_illegal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(o_flush && o_illegal));

endmodule

/* hw/exec_stage.sv */
`timescale 1ns/1ns

module exec_stage (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_valid,
   input  rv_exec_pkg::inst_t    i_inst,
   input  rv_exec_pkg::xlen_t    i_pc,
   input  rv_exec_pkg::xlen_t    i_rs1_data,
   input  rv_exec_pkg::xlen_t    i_rs2_data,
   output logic                  o_wb_valid,
   output rv_exec_pkg::reg_idx_t o_wb_rd,
   output rv_exec_pkg::xlen_t    o_wb_data,
   output logic                  o_flush,
   output rv_exec_pkg::pc_tgt_t  o_pc_tgt,
   output logic                  o_illegal
);

   rv_exec_pkg::dec_op_t dec_op;
   rv_exec_pkg::xlen_t   alu_result;
   logic                 alu_flush;    // Also drops the next strobe
   rv_exec_pkg::pc_tgt_t alu_pc_tgt;

   inst_decoder u_decoder (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_valid    (i_valid),
      .i_inst     (i_inst),
      .i_pc       (i_pc),
      .i_rs1_data (i_rs1_data),
      .i_rs2_data (i_rs2_data),
      .i_flush    (alu_flush),
      .o_op       (dec_op)
   );

   alu u_alu (
      .i_fu_sel   (dec_op.fu_sel),
      .i_pc       (dec_op.pc),
      .i_operand1 (dec_op.operand1),
      .i_operand2 (dec_op.operand2),
      .i_rop2     (dec_op.rop2),
      .o_result   (alu_result),
      .o_flush    (alu_flush),
      .o_pc_tgt   (alu_pc_tgt)
   );

   exec_result u_result (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_op       (dec_op),
      .i_result   (alu_result),
      .i_flush    (alu_flush),
      .i_pc_tgt   (alu_pc_tgt),
      .o_wb_valid (o_wb_valid),
      .o_wb_rd    (o_wb_rd),
      .o_wb_data  (o_wb_data),
      .o_flush    (o_flush),
      .o_pc_tgt   (o_pc_tgt),
      .o_illegal  (o_illegal)
   );

endmodule

/* tb/exec_stage_tb.sv */
`timescale 1ns/1ns

module exec_stage_tb;

   localparam int ALU_N = 300;
   localparam int BR_N  = 150;
   localparam int JMP_N = 40;
   localparam int DROP_N = 20;
   localparam int ILL_N = 40;
   // Each test drains two cycles after its last strobe
   localparam int LIMIT = 11 + (2 * ALU_N + 2) + (BR_N + 2) + (2 * JMP_N + 2)
                          + (4 * DROP_N + 2) + (ILL_N + 2) + 50;

   typedef struct packed {
      logic                  wb_valid;
      rv_exec_pkg::reg_idx_t rd;
      rv_exec_pkg::xlen_t    data;
      logic                  flush;
      rv_exec_pkg::pc_tgt_t  tgt;
      logic                  illegal;
   } exp_t;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  in_valid;
   rv_exec_pkg::inst_t    in_inst;
   rv_exec_pkg::xlen_t    in_pc;
   rv_exec_pkg::xlen_t    in_rs1;
   rv_exec_pkg::xlen_t    in_rs2;
   logic                  wb_valid;
   rv_exec_pkg::reg_idx_t wb_rd;
   rv_exec_pkg::xlen_t    wb_data;
   logic                  out_flush;
   rv_exec_pkg::pc_tgt_t  out_tgt;
   logic                  out_illegal;

   logic [63:0]        rng_state;
   exp_t               exp_q[$];    // Expected outputs, head is the current cycle
   rv_exec_pkg::xlen_t held_data;   // Writeback data holds between strobes
   string              cur_test;
   int                 n_pass;
   int                 n_fail;
   int                 test_fail;
   int                 cycle_cnt;

   exec_stage i_dut (
      .i_clk      (clk),
      .i_rst_n    (rst_n),
      .i_valid    (in_valid),
      .i_inst     (in_inst),
      .i_pc       (in_pc),
      .i_rs1_data (in_rs1),
      .i_rs2_data (in_rs2),
      .o_wb_valid (wb_valid),
      .o_wb_rd    (wb_rd),
      .o_wb_data  (wb_data),
      .o_flush    (out_flush),
      .o_pc_tgt   (out_tgt),
      .o_illegal  (out_illegal)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < LIMIT) begin
         @(posedge clk);
         cycle_cnt = cycle_cnt + 1;
      end
      $display("Timeout after %0d cycles, the tests did not complete", LIMIT);
      $display("STATUS: FAIL");
      $finish;
   end

   function automatic logic [63:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 7);
      rng_state = rng_state ^ (rng_state << 17);
      return rng_state;
   endfunction

   // ########################################
   // Reference model
   // ########################################

   function automatic exp_t model_exec(input rv_exec_pkg::inst_t inst,
                                       input rv_exec_pkg::xlen_t pc,
                                       input rv_exec_pkg::xlen_t rs1,
                                       input rv_exec_pkg::xlen_t rs2);
      exp_t               e;
      rv_exec_pkg::xlen_t ii, iu, ij, ib, r, t;
      logic [2:0]         f3;
      logic [9:0]         fn;
      logic               ill;
      logic               tk;
      ii = {{52{inst[31]}}, inst[31:20]};
      iu = {{32{inst[31]}}, inst[31:12], 12'h000};
      ij = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      ib = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      f3 = inst[14:12];
      fn = {inst[31:25], f3};
      e = '0;
      r = '0;
      t = '0;
      ill = 1'b0;
      tk = 1'b0;
      e.rd = inst[11:7];
      e.wb_valid = 1'b1;
      case (inst[6:0])
         rv_exec_pkg::OPC_LUI:   r = iu;
         rv_exec_pkg::OPC_AUIPC: r = pc + iu;
         rv_exec_pkg::OPC_JAL: begin
            tk = 1'b1;
            t = pc + ij;
            r = {pc[63:2] + 62'd1, 2'b00};
         end
         rv_exec_pkg::OPC_JALR: begin
            ill = (f3 != 3'd0);
            tk = 1'b1;
            t = rs1 + ii;
            r = {pc[63:2] + 62'd1, 2'b00};
         end
         rv_exec_pkg::OPC_BRANCH: begin
            e.wb_valid = 1'b0;
            t = pc + ib;
            case (f3)
               3'd0:    tk = (rs1 == rs2);
               3'd1:    tk = (rs1 != rs2);
               3'd4:    tk = ($signed(rs1) < $signed(rs2));
               3'd5:    tk = ($signed(rs1) >= $signed(rs2));
               3'd6:    tk = (rs1 < rs2);
               3'd7:    tk = (rs1 >= rs2);
               default: ill = 1'b1;
            endcase
         end
         rv_exec_pkg::OPC_OP_IMM: begin
            case (f3)
               3'd0: r = rs1 + ii;
               3'd2: r = ($signed(rs1) < $signed(ii)) ? 64'd1 : 64'd0;
               3'd3: r = (rs1 < ii) ? 64'd1 : 64'd0;
               3'd4: r = rs1 ^ ii;
               3'd6: r = rs1 | ii;
               3'd7: r = rs1 & ii;
               3'd1: begin
                  r = rs1 << inst[25:20];
                  ill = (inst[31:26] != 6'b000000);
               end
               default: begin
                  if (inst[30])
                     r = $signed(rs1) >>> inst[25:20];
                  else
                     r = rs1 >> inst[25:20];
                  ill = (inst[31:26] != 6'b000000) && (inst[31:26] != 6'b010000);
               end
            endcase
         end
         rv_exec_pkg::OPC_OP: begin
            case (fn)
               10'b0000000_000: r = rs1 + rs2;
               10'b0100000_000: r = rs1 - rs2;
               10'b0000000_001: r = rs1 << rs2[5:0];
               10'b0000000_010: r = ($signed(rs1) < $signed(rs2)) ? 64'd1 : 64'd0;
               10'b0000000_011: r = (rs1 < rs2) ? 64'd1 : 64'd0;
               10'b0000000_100: r = rs1 ^ rs2;
               10'b0000000_101: r = rs1 >> rs2[5:0];
               10'b0100000_101: r = $signed(rs1) >>> rs2[5:0];
               10'b0000000_110: r = rs1 | rs2;
               10'b0000000_111: r = rs1 & rs2;
               default:         ill = 1'b1;
            endcase
         end
         rv_exec_pkg::OPC_OP_IMM_32: begin
            r = rs1 + ii;                     // ADDIW
            r = {{32{r[31]}}, r[31:0]};
            ill = (f3 != 3'd0);
         end
         default: ill = 1'b1;
      endcase
      e.flush = tk & ~ill;
      e.tgt = e.flush ? t[63:2] : '0;
      e.data = r;
      if (ill) begin
         e.wb_valid = 1'b0;
         e.illegal = 1'b1;
      end
      return e;
   endfunction

   // ########################################
   // Stimulus generators
   // ########################################

   function automatic rv_exec_pkg::inst_t alu_inst();
      logic [63:0]        r;
      rv_exec_pkg::inst_t ins;
      r = next_rand();
      ins = r[31:0];
      case (r[34:32])
         3'd0: ins[6:0] = rv_exec_pkg::OPC_LUI;
         3'd1: ins[6:0] = rv_exec_pkg::OPC_AUIPC;
         3'd2: begin
            ins[6:0] = rv_exec_pkg::OPC_OP_IMM_32;
            ins[14:12] = 3'd0;
         end
         3'd3, 3'd4: begin
            ins[6:0] = rv_exec_pkg::OPC_OP_IMM;
            if (ins[14:12] == 3'd1)
               ins[31:26] = 6'b000000;
            else if (ins[14:12] == 3'd5)
               ins[31:26] = {1'b0, r[40], 4'b0000};  // SRLI or SRAI
         end
         default: begin
            ins[6:0] = rv_exec_pkg::OPC_OP;
            if ((ins[14:12] == 3'd0 || ins[14:12] == 3'd5) && r[40])
               ins[31:25] = 7'b0100000;
            else
               ins[31:25] = 7'b0000000;
         end
      endcase
      return ins;
   endfunction

   function automatic rv_exec_pkg::inst_t branch_inst();
      logic [63:0]        r;
      rv_exec_pkg::inst_t ins;
      r = next_rand();
      ins = r[31:0];
      ins[6:0] = rv_exec_pkg::OPC_BRANCH;
      if (ins[14:13] == 2'b01)
         ins[14:12] = {2'b10, r[40]};          // Skip the reserved codes
      return ins;
   endfunction

   function automatic rv_exec_pkg::inst_t jump_inst(input logic use_jalr);
      logic [63:0]        r;
      rv_exec_pkg::inst_t ins;
      r = next_rand();
      ins = r[31:0];
      ins[6:0] = use_jalr ? rv_exec_pkg::OPC_JALR : rv_exec_pkg::OPC_JAL;
      if (use_jalr)
         ins[14:12] = 3'd0;
      return ins;
   endfunction

   function automatic rv_exec_pkg::inst_t illegal_inst();
      logic [63:0]        r;
      rv_exec_pkg::inst_t ins;
      r = next_rand();
      ins = r[31:0];
      case (r[34:32])
         3'd0: ins[6:0] = 7'b0000011;           // Load
         3'd1: ins[6:0] = 7'b0100011;           // Store
         3'd2: ins[6:0] = 7'b1110011;           // System
         3'd3: begin
            ins[6:0] = rv_exec_pkg::OPC_OP;
            ins[31:25] = 7'b0000001;            // M extension
         end
         3'd4: begin
            ins[6:0] = rv_exec_pkg::OPC_BRANCH;
            ins[14:12] = {2'b01, r[40]};
         end
         3'd5: begin
            ins[6:0] = rv_exec_pkg::OPC_JALR;
            ins[14:12] = {r[41:40], 1'b1};
         end
         3'd6: begin
            ins[6:0] = rv_exec_pkg::OPC_OP_IMM_32;
            ins[14:12] = 3'd1;                  // SLLIW is not supported
         end
         default: begin
            ins[6:0] = rv_exec_pkg::OPC_OP_IMM;
            ins[14:12] = 3'd1;
            ins[31:26] = 6'b010000;
         end
      endcase
      return ins;
   endfunction

   function automatic rv_exec_pkg::xlen_t edge_val(input logic [2:0] k);
      case (k)
         3'd0:    return 64'h0000_0000_0000_0000;
         3'd1:    return 64'hffff_ffff_ffff_ffff;
         3'd2:    return 64'h8000_0000_0000_0000;
         3'd3:    return 64'h7fff_ffff_ffff_ffff;
         3'd4:    return 64'h0000_0000_0000_0001;
         default: return next_rand();
      endcase
   endfunction

   function automatic rv_exec_pkg::xlen_t rand_pc();
      return next_rand() & ~64'h1;
   endfunction

   // ########################################
   // Drive and check
   // ########################################

   task automatic check_val(input string sig, input logic [63:0] expv, input logic [63:0] actv);
      assert (actv === expv) n_pass = n_pass + 1;
      else begin
         n_fail = n_fail + 1;
         test_fail = test_fail + 1;
         $display("[FAIL] %s %s expected %h actual %h", cur_test, sig, expv, actv);
      end
   endtask

   task automatic step(input logic vld, input rv_exec_pkg::inst_t ins,
                       input rv_exec_pkg::xlen_t pc, input rv_exec_pkg::xlen_t rs1,
                       input rv_exec_pkg::xlen_t rs2);
      exp_t e;
      exp_t nxt;
      @(negedge clk);
      e = exp_q.pop_front();
      if (e.wb_valid)
         held_data = e.data;
      check_val("o_wb_valid", 64'(e.wb_valid), 64'(wb_valid));
      check_val("o_wb_data", held_data, wb_data);
      check_val("o_flush", 64'(e.flush), 64'(out_flush));
      check_val("o_pc_tgt", 64'(e.tgt), 64'(out_tgt));
      check_val("o_illegal", 64'(e.illegal), 64'(out_illegal));
      if (e.wb_valid)
         check_val("o_wb_rd", 64'(e.rd), 64'(wb_rd));
      in_valid = vld;
      in_inst = ins;
      in_pc = pc;
      in_rs1 = rs1;
      in_rs2 = rs2;
      nxt = '0;
      if (vld && !exp_q[0].flush)            // Shadow of a predicted flush is dropped
         nxt = model_exec(ins, pc, rs1, rs2);
      exp_q.push_back(nxt);
   endtask

   task automatic idle();
      step(1'b0, '0, '0, '0, '0);
   endtask

   task automatic end_test();
      idle();
      idle();
      $display("Test %s finished with %0d failures", cur_test, test_fail);
      test_fail = 0;
   endtask

   initial begin
      logic [63:0]        r;
      rv_exec_pkg::xlen_t a;
      rv_exec_pkg::xlen_t b;
      rv_exec_pkg::inst_t ins;
      rng_state = 64'd54;
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_inst = '0;
      in_pc = '0;
      in_rs1 = '0;
      in_rs2 = '0;
      held_data = '0;
      n_pass = 0;
      n_fail = 0;
      test_fail = 0;
      exp_q.push_back('0);
      exp_q.push_back('0);

      cur_test = "reset";
      repeat (8) idle();
      rst_n = 1'b1;
      idle();
      end_test();

      cur_test = "alu";
      for (int i = 0; i < ALU_N; i++) begin
         r = next_rand();
         step(1'b1, alu_inst(), rand_pc(), next_rand(), next_rand());
         if (r[0])
            idle();
      end
      end_test();

      cur_test = "branch";
      for (int i = 0; i < BR_N; i++) begin
         r = next_rand();
         a = next_rand();
         case (r[1:0])
            2'd0: b = a;
            2'd1: begin
               a = edge_val(r[4:2]);
               b = edge_val(r[7:5]);
            end
            2'd2: b = a ^ 64'h8000_0000_0000_0000;
            default: b = next_rand();
         endcase
         step(1'b1, branch_inst(), rand_pc(), a, b);
      end
      end_test();

      cur_test = "jump";
      for (int i = 0; i < JMP_N; i++) begin
         r = next_rand();
         step(1'b1, jump_inst(r[0]), rand_pc(), next_rand(), next_rand());
         idle();
      end
      end_test();

      cur_test = "drop";
      for (int i = 0; i < DROP_N; i++) begin
         a = next_rand();
         if (i % 2 == 0) begin
            ins = jump_inst(i % 4 == 2);
         end else begin
            ins = branch_inst();
            ins[14:12] = 3'd0;                  // BEQ with equal operands is taken
         end
         step(1'b1, ins, rand_pc(), a, a);
         step(1'b1, alu_inst(), rand_pc(), next_rand(), next_rand());
         step(1'b1, alu_inst(), rand_pc(), next_rand(), next_rand());
         idle();
      end
      end_test();

      cur_test = "illegal";
      for (int i = 0; i < ILL_N; i++)
         step(1'b1, illegal_inst(), rand_pc(), next_rand(), next_rand());
      end_test();

      $display("Checks passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* compile.f */
hw/rv_exec_pkg.sv
hw/inst_decoder.sv
hw/alu.sv
hw/exec_result.sv
hw/exec_stage.sv
tb/exec_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
